//--- adc_ctrl_tests.txt
# test <name> <adc base hex> <data_buf_full> <trigger pulses> <flags: bad under unexp short ovf>
# cmd <command word hex> and exp <expected data word hex> belong to the test above them
test default_order 0100 0 0 00000
cmd 400001f4
exp 21010100
exp 61034102
exp a1058104
exp e107c106
test set_order 0a00 0 0 00000
cmd 20990bcb
cmd 400001f4
exp 2a016a03
exp aa05ea07
exp 4a020a00
exp 8a04ca06
test trigger_wait 0040 0 3 00000
cmd 10000003
cmd 400001f4
exp 20410040
exp 60434042
exp a0458044
exp e047c046
test delay_short 0000 0 0 00010
cmd 40000001
test bad_opcode 0000 0 0 10000
cmd e0000000
test underflow 0000 0 0 01000
cmd 08000005
test buffer_full 0000 1 0 00001
cmd 400001f4

//--- flist.f
adc_ctrl_pkg.sv
spi_frame_if.sv
cmd_sequencer.sv
spi_frame_engine.sv
miso_capture.sv
sample_packer.sv
adc_ctrl_top.sv
tb_adc_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the ADC controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_adc_ctrl -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_adc_ctrl > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Testbench reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
exit 0

//--- tb_adc_ctrl.sv
`default_nettype none

module tb_adc_ctrl;

  localparam int RESET_CYCLES    = 8;
  localparam int RUN_LIMIT       = 1500; // Cycles for one test to reach its end
  localparam int QUIET_CYCLES    = 300;  // Longer than a whole nine-frame read
  localparam int CYCLES_PER_TEST = 2000;

  logic                     clk;
  logic                     resetn;
  adc_ctrl_pkg::cmd_word_t  cmd_buf_word;
  logic                     cmd_buf_empty;
  logic                     cmd_buf_rd_en;
  logic                     data_buf_full;
  logic                     data_buf_wr_en;
  adc_ctrl_pkg::data_word_t data_word;
  logic                     trigger;
  logic                     waiting_for_trig;
  logic                     n_cs;
  logic                     mosi;
  logic                     miso;
  logic                     bad_cmd;
  logic                     cmd_buf_underflow;
  logic                     unexp_trig;
  logic                     delay_too_short;
  logic                     data_buf_overflow;
  logic [4:0]               flag_vec; // Same order as the data file

  ////////////////////
  // Test table

  string                    t_name[$];
  logic [12:0]              t_base[$]; // ADC result base
  int                       t_full[$];
  int                       t_trig[$]; // Trigger pulses to give
  logic [4:0]               t_flags[$];
  int                       t_ncmd[$];
  int                       t_nexp[$];
  adc_ctrl_pkg::cmd_word_t  all_cmd[$]; // Commands of all tests, in file order
  adc_ctrl_pkg::data_word_t all_exp[$];
  int                       n_tests = 0;

  // Running test
  adc_ctrl_pkg::cmd_word_t  cmd_q[$]; // Command FIFO, head at 0
  adc_ctrl_pkg::data_word_t exp_q[$];
  logic [12:0]              cur_base;
  adc_ctrl_pkg::sample_t    req;      // Request bits seen on mosi
  adc_ctrl_pkg::sample_t    resp;     // Result going out in this frame
  int                       bit_idx;
  int                       trig_left;
  int                       trig_gap;

  assign flag_vec = {bad_cmd, cmd_buf_underflow, unexp_trig, delay_too_short, data_buf_overflow};

  adc_ctrl_top #(.CS_HIGH_CYCLES(4)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // Period 40
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Watchdog sized from the number of tests
  initial begin
    wait (n_tests > 0);
    repeat (n_tests * CYCLES_PER_TEST) @(posedge clk);
    $display("Watchdog expired after %0d cycles", n_tests * CYCLES_PER_TEST);
    $display("Simulation failed");
    $fatal(1);
  end

  ////////////////////
  // Models

  // ADC side of the link, one bit per falling edge
  task automatic model_adc_bit(input string name);
    if (n_cs) begin
      bit_idx = 0;
      miso    = 1'b0; // Idle between frames
    end else if (bit_idx < adc_ctrl_pkg::FRAME_BITS) begin
      req[15 - bit_idx] = mosi;
      miso              = resp[15 - bit_idx]; // MSB first
      bit_idx++;
      if (bit_idx == adc_ctrl_pkg::FRAME_BITS) begin
        // Request is 1,0 then the channel then eleven zeros
        assert (req == {2'b10, req[13:11], 11'd0}) else
          abort_run($sformatf("ERR %s request frame expected %h actual %h",
                              name, {2'b10, req[13:11], 11'd0}, req));
        // Answer to this request leaves in the next frame
        resp = {req[13:11], 13'(cur_base + 13'(req[13:11]))};
      end
    end
  endtask

  task automatic drive_trigger(input string name);
    if (trigger) begin // Pulse just seen, wait stays open only while pulses remain
      assert (waiting_for_trig == (trig_left != 0)) else
        abort_run($sformatf("ERR %s waiting_for_trig expected %0b actual %0b",
                            name, trig_left != 0, waiting_for_trig));
    end
    if (trig_left != 0 && waiting_for_trig && trig_gap == 0) begin
      trigger  = 1'b1;
      trig_left--;
      trig_gap = 3; // Quiet cycles between pulses
    end else begin
      trigger = 1'b0;
      if (trig_gap != 0) trig_gap--;
    end
  endtask

  // One clock: check writes, drive inputs, pop the command FIFO
  task automatic run_cycle(input string name);
    @(negedge clk);
    if (data_buf_wr_en) begin
      assert (exp_q.size() != 0) else
        abort_run($sformatf("Test %s wrote data word %h after all expected words",
                            name, data_word));
      assert (data_word == exp_q[0]) else
        abort_run($sformatf("ERR %s data word expected %h actual %h", name, exp_q[0], data_word));
      void'(exp_q.pop_front());
    end
    model_adc_bit(name);
    drive_trigger(name);
    cmd_buf_empty = (cmd_q.size() == 0);
    cmd_buf_word  = cmd_buf_empty ? '0 : cmd_q[0]; // FWFT head
    #5; // Read enable settles from the new inputs
    if (cmd_buf_rd_en) begin
      assert (!cmd_buf_empty) else
        abort_run($sformatf("Test %s read from an empty command buffer", name));
      void'(cmd_q.pop_front());
    end
  endtask

  task automatic apply_reset(input logic [12:0] base);
    @(negedge clk);
    resetn        = 1'b0;
    cmd_buf_empty = 1'b1;
    cmd_buf_word  = '0;
    data_buf_full = 1'b0;
    trigger       = 1'b0;
    miso          = 1'b0;
    cmd_q.delete();
    exp_q.delete();
    trig_left = 0;
    trig_gap  = 0;
    bit_idx   = 0;
    req       = '0;
    resp      = '0; // Frame 0 result is ignored
    cur_base  = base;
    repeat (RESET_CYCLES) @(negedge clk);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    int                      fd;
    int                      r;
    int                      c;
    int                      cycles;
    string                   key;
    string                   name;
    logic [12:0]             base;
    int                      full;
    int                      ntrig;
    logic [4:0]              flags;
    adc_ctrl_pkg::cmd_word_t word;
    resetn        = 1'b0;
    cmd_buf_word  = '0;
    cmd_buf_empty = 1'b1;
    data_buf_full = 1'b0;
    trigger       = 1'b0;
    miso          = 1'b0;

    fd = $fopen("adc_ctrl_tests.txt", "r");
    assert (fd != 0) else abort_run("Cannot open adc_ctrl_tests.txt");
    while ($fscanf(fd, "%s", key) == 1) begin
      if (key[0] == "#") begin
        c = 0;
        while (c != "\n" && c != -1) c = $fgetc(fd); // Skip comment line
      end else if (key == "test") begin
        r = $fscanf(fd, "%s %h %d %d %b", name, base, full, ntrig, flags);
        assert (r == 5) else abort_run("Malformed test record in adc_ctrl_tests.txt");
        t_name.push_back(name);
        t_base.push_back(base);
        t_full.push_back(full);
        t_trig.push_back(ntrig);
        t_flags.push_back(flags);
        t_ncmd.push_back(0);
        t_nexp.push_back(0);
      end else if (key == "cmd" || key == "exp") begin
        r = $fscanf(fd, "%h", word);
        assert (r == 1 && t_name.size() != 0) else abort_run("Malformed cmd or exp record");
        if (key == "cmd") begin
          all_cmd.push_back(word);
          t_ncmd[t_ncmd.size() - 1]++;
        end else begin
          all_exp.push_back(word);
          t_nexp[t_nexp.size() - 1]++;
        end
      end else begin
        abort_run($sformatf("Unknown record %s in adc_ctrl_tests.txt", key));
      end
    end
    $fclose(fd);
    assert (t_name.size() != 0) else abort_run("No tests found in adc_ctrl_tests.txt");
    n_tests = t_name.size();

    for (int t = 0; t < n_tests; t++) begin
      apply_reset(t_base[t]);
      repeat (t_ncmd[t]) cmd_q.push_back(all_cmd.pop_front());
      repeat (t_nexp[t]) exp_q.push_back(all_exp.pop_front());
      trig_left     = t_trig[t];
      data_buf_full = (t_full[t] != 0); // Held for the whole test
      resetn        = 1'b1;
      cycles        = 0;
      // End of test: commands and triggers used up, then a raised flag,
      // or all words when the test expects no flag
      while (!(cmd_q.size() == 0 && trig_left == 0 &&
               (flag_vec != '0 || (exp_q.size() == 0 && t_flags[t] == '0)))) begin
        run_cycle(t_name[t]);
        cycles++;
        assert (cycles < RUN_LIMIT) else
          abort_run($sformatf("Test %s did not finish in %0d cycles", t_name[t], RUN_LIMIT));
      end
      repeat (QUIET_CYCLES) run_cycle(t_name[t]); // Late flags or stray writes
      assert (flag_vec == t_flags[t]) else
        abort_run($sformatf("ERR %s flags expected %b actual %b",
                            t_name[t], t_flags[t], flag_vec));
      assert (exp_q.size() == 0) else
        abort_run($sformatf("Test %s is missing %0d data words", t_name[t], exp_q.size()));
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- adc_ctrl_top.sv
`default_nettype none

module adc_ctrl_top #(
  parameter int CS_HIGH_CYCLES = 4
) (
  input  logic                     clk,
  input  logic                     resetn,
  // Command buffer, first word fall through
  input  adc_ctrl_pkg::cmd_word_t  cmd_buf_word,
  input  logic                     cmd_buf_empty,
  output logic                     cmd_buf_rd_en,
  // Data buffer
  input  logic                     data_buf_full,
  output logic                     data_buf_wr_en,
  output adc_ctrl_pkg::data_word_t data_word,
  // Trigger
  input  logic                     trigger,
  output logic                     waiting_for_trig,
  // SPI
  output logic                     n_cs,
  output logic                     mosi,
  input  logic                     miso,
  // Sticky errors
  output logic                     bad_cmd,
  output logic                     cmd_buf_underflow,
  output logic                     unexp_trig,
  output logic                     delay_too_short,
  output logic                     data_buf_overflow
);

  logic                  halt;
  logic                  overflow;
  logic                  sample_valid;
  adc_ctrl_pkg::sample_t sample;

  spi_frame_if frm_if (.clk(clk));

  assign n_cs = frm_if.n_cs;

  cmd_sequencer seq_i (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_buf_word      (cmd_buf_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .cmd_buf_rd_en     (cmd_buf_rd_en),
    .trigger           (trigger),
    .waiting_for_trig  (waiting_for_trig),
    .overflow          (overflow),
    .halt              (halt),
    .frm               (frm_if.sequencer),
    .bad_cmd           (bad_cmd),
    .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig        (unexp_trig),
    .delay_too_short   (delay_too_short),
    .data_buf_overflow (data_buf_overflow)
  );

  spi_frame_engine #(.CS_HIGH_CYCLES(CS_HIGH_CYCLES)) eng_i (
    .clk    (clk),
    .resetn (resetn),
    .halt   (halt),
    .frm    (frm_if.engine),
    .mosi   (mosi)
  );

  miso_capture cap_i (
    .clk          (clk),
    .resetn       (resetn),
    .miso         (miso),
    .frm          (frm_if.capture),
    .sample_valid (sample_valid),
    .sample       (sample)
  );

  sample_packer pack_i (
    .clk            (clk),
    .resetn         (resetn),
    .halt           (halt),
    .sample_valid   (sample_valid),
    .sample         (sample),
    .data_buf_full  (data_buf_full),
    .data_buf_wr_en (data_buf_wr_en),
    .data_word      (data_word),
    .overflow       (overflow)
  );

endmodule

`default_nettype wire

//--- sample_packer.sv
`default_nettype none

module sample_packer (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     halt,
  input  logic                     sample_valid,
  input  adc_ctrl_pkg::sample_t    sample,
  input  logic                     data_buf_full,
  output logic                     data_buf_wr_en,
  output adc_ctrl_pkg::data_word_t data_word,
  output logic                     overflow
);

  logic                  have_low; // Low half waiting for its partner
  adc_ctrl_pkg::sample_t low_half;
  logic                  pair_rdy;

  assign pair_rdy = sample_valid && have_low && !halt;

  ////////////////////
  // Pairing

  always_ff @(posedge clk) begin
    if (!resetn || halt) have_low <= 1'b0; // Drop a half pair on halt
    else if (sample_valid) have_low <= ~have_low;
  end

  always_ff @(posedge clk) begin
    if (sample_valid && !have_low) low_half <= sample; // First result of the pair
  end

  ////////////////////
  // Buffer write

  always_ff @(posedge clk) begin
    if (!resetn) begin
      data_buf_wr_en <= 1'b0;
      overflow       <= 1'b0;
    end else begin
      data_buf_wr_en <= pair_rdy && !data_buf_full;
      overflow       <= pair_rdy && data_buf_full; // Pair lost, no stall
    end
  end

  always_ff @(posedge clk) begin
    if (pair_rdy) data_word <= {sample, low_half}; // New result on top
  end

  // A held valid would pair a result with itself
  a_valid_is_pulse: assert property (@(posedge clk) disable iff (!resetn)
    sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

//--- miso_capture.sv
`default_nettype none

module miso_capture (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  miso,
  spi_frame_if.capture          frm,
  output logic                  sample_valid,
  output adc_ctrl_pkg::sample_t sample
);

  localparam int CNT_W = $clog2(adc_ctrl_pkg::FRAME_BITS);

  logic [CNT_W-1:0] bit_cnt; // Bits taken so far, wraps per frame
  logic             take;

  // Only frames that carry a previous result
  assign take = !frm.n_cs && frm.rx_expected;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bit_cnt      <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= take && (bit_cnt == CNT_W'(adc_ctrl_pkg::FRAME_BITS - 1)); // Last bit
      if (take) bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // MSB arrives first
  always_ff @(posedge clk) begin
    if (take) sample <= {sample[adc_ctrl_pkg::FRAME_BITS-2:0], miso};
  end

endmodule

`default_nettype wire

//--- spi_frame_engine.sv
`default_nettype none

module spi_frame_engine #(
  parameter int CS_HIGH_CYCLES = 4 // n_cs high time before each frame, 1..255
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        halt,
  spi_frame_if.engine frm,
  output logic        mosi
);

  localparam int BIT_W = $clog2(adc_ctrl_pkg::FRAME_BITS + 1);

  logic [7:0]            cs_timer; // n_cs high countdown
  logic [BIT_W-1:0]      bit_cnt;  // Bits left in the frame
  adc_ctrl_pkg::sample_t shreg;    // MOSI shift register

  ////////////////////
  // Chip select and bit counter

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      cs_timer       <= '0;
      bit_cnt        <= '0;
      frm.n_cs       <= 1'b1; // Idle high
      frm.frame_done <= 1'b0;
    end else begin
      frm.frame_done <= 1'b0;
      if (frm.start) cs_timer <= 8'(CS_HIGH_CYCLES);
      else if (cs_timer != '0) cs_timer <= cs_timer - 1'b1;

      if (cs_timer == 8'd1) begin
        frm.n_cs <= 1'b0;                          // High time over, open frame
        bit_cnt  <= BIT_W'(adc_ctrl_pkg::FRAME_BITS);
      end else if (bit_cnt != '0) begin
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == BIT_W'(1)) begin
          frm.n_cs       <= 1'b1; // Close frame
          frm.frame_done <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // MOSI shifter

  // Shifts MSB first while the frame is open
  always_ff @(posedge clk) begin
    if (frm.start) shreg <= frm.tx_word;
    else if (!frm.n_cs) shreg <= {shreg[adc_ctrl_pkg::FRAME_BITS-2:0], 1'b0};
  end

  assign mosi = shreg[adc_ctrl_pkg::FRAME_BITS-1] & ~frm.n_cs; // Quiet low between frames

  // New requests only reach an idle engine
  a_start_when_idle: assert property (@(posedge clk) disable iff (!resetn || halt)
    frm.start |-> (frm.n_cs && cs_timer == '0 && bit_cnt == '0));

endmodule

`default_nettype wire

//--- cmd_sequencer.sv
`default_nettype none

module cmd_sequencer (
  input  logic                    clk,
  input  logic                    resetn,
  input  adc_ctrl_pkg::cmd_word_t cmd_buf_word,
  input  logic                    cmd_buf_empty,
  output logic                    cmd_buf_rd_en,
  input  logic                    trigger,
  output logic                    waiting_for_trig,
  input  logic                    overflow,      // Pulse from the packer
  output logic                    halt,
  spi_frame_if.sequencer          frm,
  output logic                    bad_cmd,
  output logic                    cmd_buf_underflow,
  output logic                    unexp_trig,
  output logic                    delay_too_short,
  output logic                    data_buf_overflow
);

  typedef enum logic [2:0] {IDLE, DELAY, TRIG_WAIT, ADC_RD, ADC_WAIT, ERROR} state_e;

  localparam int IDX_W = 4; // Frame index 0..8
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(adc_ctrl_pkg::N_CHAN);

  state_e                              state, state_nxt;
  adc_ctrl_pkg::opcode_e               opc;
  logic [adc_ctrl_pkg::COUNT_W-1:0]    count_f;
  logic                                wait_trig, expect_next;
  logic [adc_ctrl_pkg::COUNT_W-1:0]    delay_timer, trig_cnt;
  logic [adc_ctrl_pkg::CHAN_W-1:0]     order [adc_ctrl_pkg::N_CHAN];
  logic [IDX_W-1:0]                    word_idx, next_idx;
  logic [adc_ctrl_pkg::CHAN_W-1:0]     next_chan;
  logic                                live, accept, opc_ok, is_wait_cmd;
  logic                                delay_done, trig_done, wait_done, cmd_done;
  logic                                trig_ok, read_end;
  logic                                bad_now, under_now, unexp_now, short_now, ovf_now, err_now;

  ////////////////////
  // Command decode

  assign opc         = adc_ctrl_pkg::opcode_e'(cmd_buf_word[adc_ctrl_pkg::OPC_HI:adc_ctrl_pkg::OPC_LO]);
  assign count_f     = cmd_buf_word[adc_ctrl_pkg::COUNT_W-1:0];
  assign opc_ok      = opc inside {adc_ctrl_pkg::NO_OP, adc_ctrl_pkg::SET_ORD, adc_ctrl_pkg::ADC_RD};
  assign is_wait_cmd = (opc == adc_ctrl_pkg::NO_OP) || (opc == adc_ctrl_pkg::ADC_RD);

  // Wait completion
  assign delay_done = (delay_timer == '0);
  assign trig_done  = (trigger && trig_cnt == 1) || (trig_cnt == '0); // Count 1 ends on its trigger
  assign wait_done  = wait_trig ? trig_done : delay_done;

  assign cmd_done = (state == IDLE)
                    || (state == DELAY && delay_done)
                    || (state == TRIG_WAIT && trig_done)
                    || (state == ADC_WAIT && wait_done);

  assign live          = (state != ERROR);
  assign cmd_buf_rd_en = live && cmd_done && !cmd_buf_empty; // FWFT pop
  assign accept        = cmd_buf_rd_en;

  // Triggers are expected only in a trigger wait
  assign trig_ok          = (state == TRIG_WAIT) || (state == ADC_WAIT && wait_trig);
  assign waiting_for_trig = trig_ok;
  assign halt             = (state == ERROR);

  // Frame sequencing, frame 8 only flushes the last result
  assign next_idx  = word_idx + 1'b1;
  assign next_chan = (next_idx == LAST_IDX) ? '0 : order[next_idx[adc_ctrl_pkg::CHAN_W-1:0]];
  assign read_end  = (state == ADC_RD) && frm.frame_done && (word_idx == LAST_IDX);

  ////////////////////
  // Error detection

  assign bad_now   = accept && !opc_ok;
  assign under_now = live && cmd_done && expect_next && cmd_buf_empty;
  assign unexp_now = live && trigger && !trig_ok && (trig_cnt <= 1);
  assign short_now = (state == ADC_RD) && !wait_trig && delay_done; // Delay ran out mid-read
  assign ovf_now   = live && overflow;
  assign err_now   = bad_now || under_now || unexp_now || short_now || ovf_now;

  ////////////////////
  // FSM

  always_comb begin
    state_nxt = state;
    if (err_now) begin
      state_nxt = ERROR; // Held until reset
    end else if (accept) begin
      case (opc)
        adc_ctrl_pkg::NO_OP:   state_nxt = cmd_buf_word[adc_ctrl_pkg::TRIG_BIT] ? TRIG_WAIT : DELAY;
        adc_ctrl_pkg::SET_ORD: state_nxt = IDLE;
        adc_ctrl_pkg::ADC_RD:  state_nxt = ADC_RD;
        default:               state_nxt = ERROR;
      endcase
    end else if (cmd_done) begin
      state_nxt = IDLE; // Buffer ran dry without a pending continue
    end else if (read_end) begin
      state_nxt = ADC_WAIT;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state           <= IDLE;
      wait_trig       <= 1'b0;
      expect_next     <= 1'b0;
      delay_timer     <= '0;
      trig_cnt        <= '0;
      word_idx        <= '0;
      frm.start       <= 1'b0;
      frm.rx_expected <= 1'b0;
    end else begin
      state     <= state_nxt;
      frm.start <= 1'b0; // Pulse only
      if (err_now || !live) begin
        wait_trig       <= 1'b0;
        expect_next     <= 1'b0;
        delay_timer     <= '0;
        trig_cnt        <= '0;
        word_idx        <= '0;
        frm.rx_expected <= 1'b0;
      end else if (accept) begin
        expect_next <= cmd_buf_word[adc_ctrl_pkg::CONT_BIT];
        wait_trig   <= is_wait_cmd && cmd_buf_word[adc_ctrl_pkg::TRIG_BIT];
        if (is_wait_cmd) begin
          // Count goes to exactly one of the two counters
          delay_timer <= cmd_buf_word[adc_ctrl_pkg::TRIG_BIT] ? '0 : count_f;
          trig_cnt    <= cmd_buf_word[adc_ctrl_pkg::TRIG_BIT] ? count_f : '0;
        end
        if (opc == adc_ctrl_pkg::ADC_RD) begin
          frm.start       <= 1'b1; // Frame 0, nothing comes back
          frm.rx_expected <= 1'b0;
          word_idx        <= '0;
        end
      end else begin
        if (!delay_done) delay_timer <= delay_timer - 1'b1;
        if (trigger && trig_cnt != '0) trig_cnt <= trig_cnt - 1'b1;
        if (state == ADC_RD && frm.frame_done && word_idx != LAST_IDX) begin
          frm.start       <= 1'b1; // Back to back with the previous frame
          frm.rx_expected <= 1'b1;
          word_idx        <= next_idx;
        end
      end
    end
  end

  // Request word, loaded alongside start
  always_ff @(posedge clk) begin
    if (accept) frm.tx_word <= adc_ctrl_pkg::otf_request(order[0]);
    else if (state == ADC_RD && frm.frame_done) frm.tx_word <= adc_ctrl_pkg::otf_request(next_chan);
  end

  ////////////////////
  // Sample order table

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < adc_ctrl_pkg::N_CHAN; i++) order[i] <= adc_ctrl_pkg::CHAN_W'(i); // Identity
    end else if (accept && opc == adc_ctrl_pkg::SET_ORD) begin
      for (int i = 0; i < adc_ctrl_pkg::N_CHAN; i++) begin
        order[i] <= cmd_buf_word[i*adc_ctrl_pkg::CHAN_W +: adc_ctrl_pkg::CHAN_W];
      end
    end
  end

  ////////////////////
  // Sticky flags

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bad_cmd           <= 1'b0;
      cmd_buf_underflow <= 1'b0;
      unexp_trig        <= 1'b0;
      delay_too_short   <= 1'b0;
      data_buf_overflow <= 1'b0;
    end else begin
      if (bad_now)   bad_cmd           <= 1'b1;
      if (under_now) cmd_buf_underflow <= 1'b1;
      if (unexp_now) unexp_trig        <= 1'b1;
      if (short_now) delay_too_short   <= 1'b1;
      if (ovf_now)   data_buf_overflow <= 1'b1;
    end
  end

  // No new frame until the engine has closed the current one
  a_start_spacing: assert property (@(posedge frm.clk) disable iff (!resetn || halt)
    frm.start |=> (!frm.start until_with frm.frame_done));

endmodule

`default_nettype wire

//--- spi_frame_if.sv
`default_nettype none

// Frame handshake between sequencer, engine and MISO capture
interface spi_frame_if (
  input logic clk
);

  logic                  start;       // One-cycle request for a new frame
  adc_ctrl_pkg::sample_t tx_word;     // Request word, valid with start
  logic                  rx_expected; // Frame carries a result back, held as a level
  logic                  frame_done;  // Pulses when n_cs returns high
  logic                  n_cs;        // Chip select, active low

  modport sequencer (input clk, output start, tx_word, rx_expected, input frame_done);
  modport engine    (input clk, input start, tx_word, output frame_done, n_cs);
  modport capture   (input clk, input n_cs, rx_expected);

endinterface

`default_nettype wire

//--- adc_ctrl_pkg.sv
`default_nettype none

package adc_ctrl_pkg;

  ////////////////////
  // Command word layout

  typedef logic [31:0] cmd_word_t; // One entry of the command buffer

  // Opcode field sits at the top of the word
  localparam int OPC_HI = 31;
  localparam int OPC_LO = 29;

  // Unlisted codes are rejected as bad commands
  typedef enum logic [2:0] {
    NO_OP   = 3'd0, // Wait cycles or triggers
    SET_ORD = 3'd1, // Load channel order
    ADC_RD  = 3'd2  // Read all channels, then wait
  } opcode_e;

  localparam int TRIG_BIT = 28; // 1 = count triggers, 0 = count cycles
  localparam int CONT_BIT = 27; // Another command must follow

  localparam int COUNT_W = 25; // Count field in bits 24:0

  ////////////////////
  // ADC geometry

  localparam int CHAN_W = 3;  // Channel index width
  localparam int N_CHAN = 8;  // Channels per read, also SET_ORD field count

  localparam int FRAME_BITS = 16; // SPI frame length

  typedef logic [FRAME_BITS-1:0] sample_t; // One ADC result or one request frame
  typedef logic [31:0] data_word_t;        // Two results, first in the low half

  ////////////////////
  // Frame helpers

  // On-the-fly sample request for channel ch
  // Layout is 1,0 then channel then zero padding
  function automatic sample_t otf_request(input logic [CHAN_W-1:0] ch);
    sample_t req;
    req = {2'b10, ch, 11'd0};
    return req;
  endfunction

endpackage

`default_nettype wire
